// File: design/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Frame shape
`define UART_DATA_BITS   8
`define UART_FRAME_BITS  11   // Start, data, parity, stop

// Receiver sample ticks per bit
`define UART_OVERSAMPLE  16

// Clock cycles per bit, one per baud select value
// Kept short for simulation, all multiples of the oversampling factor
`define UART_CLKS_PER_BIT_0  32
`define UART_CLKS_PER_BIT_1  48
`define UART_CLKS_PER_BIT_2  64
`define UART_CLKS_PER_BIT_3  96
`define UART_CLKS_PER_BIT_4  128
`define UART_CLKS_PER_BIT_5  192
`define UART_CLKS_PER_BIT_6  256
`define UART_CLKS_PER_BIT_7  384

`endif

// File: design/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

    // Baud rate choice, fastest first
    typedef enum logic [2:0] {
        BAUD_0 = 3'd0,
        BAUD_1 = 3'd1,
        BAUD_2 = 3'd2,
        BAUD_3 = 3'd3,
        BAUD_4 = 3'd4,
        BAUD_5 = 3'd5,
        BAUD_6 = 3'd6,
        BAUD_7 = 3'd7
    } baud_sel_e;

    // Link configuration shared by both endpoints
    typedef struct packed {
        baud_sel_e baud_sel;
        logic      tx_en;     // Transmit enable
        logic      rx_en;     // Receive enable
    } uart_cfg_t;

endpackage

`default_nettype wire

// File: design/uart_frame_pkg.sv
`default_nettype none

`include "uart_params.svh"

package uart_frame_pkg;

    // Transmitter states, encodings kept from the older per-bit FSM
    typedef enum logic [3:0] {
        START_BIT  = 4'b0000,
        DATA_BIT   = 4'b0001,   // Walks all data bits with an index
        PARITY_BIT = 4'b1001,
        STOP_BIT   = 4'b1010,
        IDLE       = 4'b1011,
        DISABLED   = 4'b1100
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    // One received frame
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
        logic                       parity_error;
        logic                       frame_error;    // Stop bit was low
    } rx_result_t;

endpackage

`default_nettype wire

// File: design/baud_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module baud_controller #(
    parameter int OVERSAMPLE = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  uart_cfg_pkg::baud_sel_e baud_sel,
    input  logic                  run,
    input  logic                  restart,
    output logic                  tick
);
    import uart_cfg_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT_7 + 1);

    logic [CNT_W-1:0] clks_per_bit;
    logic [CNT_W-1:0] last_count;
    logic [CNT_W-1:0] count;

    always_comb begin
        case (baud_sel)
            BAUD_0:  clks_per_bit = CNT_W'(`UART_CLKS_PER_BIT_0);
            BAUD_1:  clks_per_bit = CNT_W'(`UART_CLKS_PER_BIT_1);
            BAUD_2:  clks_per_bit = CNT_W'(`UART_CLKS_PER_BIT_2);
            BAUD_3:  clks_per_bit = CNT_W'(`UART_CLKS_PER_BIT_3);
            BAUD_4:  clks_per_bit = CNT_W'(`UART_CLKS_PER_BIT_4);
            BAUD_5:  clks_per_bit = CNT_W'(`UART_CLKS_PER_BIT_5);
            BAUD_6:  clks_per_bit = CNT_W'(`UART_CLKS_PER_BIT_6);
            default: clks_per_bit = CNT_W'(`UART_CLKS_PER_BIT_7);
        endcase
    end

    assign last_count = CNT_W'(clks_per_bit / OVERSAMPLE - 1);   // Divide per tick

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (restart) begin
            count <= '0;                    // Fresh full period
        end else if (run) begin
            if (count >= last_count)        // Also catches a baud change mid-count
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

    assign tick = run && (count >= last_count);

    // Restart precedes run, so the first run cycle starts a fresh period
    a_no_tick_at_run_start: assert property (@(posedge clk) disable iff (reset)
        $rose(run) |-> !tick)
        else $error("baud_controller: tick came in the first cycle of run");

    // Period is at least two cycles, so ticks never merge
    a_tick_single: assert property (@(posedge clk) disable iff (reset)
        tick |=> !tick)
        else $error("baud_controller: tick lasted more than one cycle");

endmodule

`default_nettype wire

// File: design/uart_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_transmitter (
    input  logic                       clk,
    input  logic                       reset,
    input  uart_cfg_pkg::uart_cfg_t    cfg,
    input  logic [`UART_DATA_BITS-1:0] tx_data,
    input  logic                       tx_wr,
    output logic                       txd,
    output logic                       tx_busy
);
    import uart_frame_pkg::*;

    localparam int IDX_W = $clog2(`UART_DATA_BITS);
    localparam logic [IDX_W-1:0] MSB_IDX = IDX_W'(`UART_DATA_BITS - 1);

    tx_state_e                  state;
    logic [`UART_DATA_BITS-1:0] data_q;     // Byte held from the write
    logic                       parity_q;
    logic [IDX_W-1:0]           bit_idx;
    logic                       accept;
    logic                       bit_tick;

    // Write taken only when idle and enabled
    assign accept = (state == IDLE) && tx_wr && cfg.tx_en;

    baud_controller #(
        .OVERSAMPLE(1)
    ) i_baud_controller (
        .clk     (clk),
        .reset   (reset),
        .baud_sel(cfg.baud_sel),
        .run     (tx_busy),         // Counts only during a frame
        .restart (accept),
        .tick    (bit_tick)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q   <= tx_data;
            parity_q <= ^tx_data;           // Even parity
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            txd     <= 1'b1;
            tx_busy <= 1'b0;
            bit_idx <= '0;
        end else begin
            case (state)
                DISABLED: begin
                    if (cfg.tx_en)
                        state <= IDLE;
                end
                IDLE: begin
                    if (accept) begin
                        state   <= START_BIT;
                        txd     <= 1'b0;
                        tx_busy <= 1'b1;
                    end
                end
                START_BIT: begin
                    if (bit_tick) begin
                        state   <= DATA_BIT;
                        bit_idx <= MSB_IDX;
                        txd     <= data_q[MSB_IDX];     // MSB goes first
                    end
                end
                DATA_BIT: begin
                    if (bit_tick) begin
                        if (bit_idx == '0) begin
                            state <= PARITY_BIT;
                            txd   <= parity_q;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                            txd     <= data_q[bit_idx - 1'b1];
                        end
                    end
                end
                PARITY_BIT: begin
                    if (bit_tick) begin
                        state <= STOP_BIT;
                        txd   <= 1'b1;
                    end
                end
                STOP_BIT: begin
                    if (bit_tick) begin
                        state   <= DISABLED;        // One pass before IDLE
                        tx_busy <= 1'b0;
                    end
                end
                default: begin
                    state   <= DISABLED;
                    txd     <= 1'b1;
                    tx_busy <= 1'b0;
                end
            endcase
        end
    end

    a_idle_not_busy: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE || state == DISABLED) |-> !tx_busy)
        else $error("uart_transmitter: tx_busy high outside a frame");

    a_line_idle_high: assert property (@(posedge clk) disable iff (reset)
        !tx_busy |-> txd)
        else $error("uart_transmitter: txd low while not busy");

endmodule

`default_nettype wire

// File: design/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_receiver (
    input  logic                       clk,
    input  logic                       reset,
    input  uart_cfg_pkg::uart_cfg_t    cfg,
    input  logic                       rxd,
    output uart_frame_pkg::rx_result_t rx_result,
    output logic                       rx_valid
);
    import uart_frame_pkg::*;

    localparam int SMP_W = $clog2(`UART_OVERSAMPLE);
    localparam int IDX_W = $clog2(`UART_DATA_BITS);
    localparam logic [SMP_W-1:0] MID_SAMPLE  = SMP_W'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [SMP_W-1:0] LAST_SAMPLE = SMP_W'(`UART_OVERSAMPLE - 1);
    localparam logic [IDX_W-1:0] LAST_BIT    = IDX_W'(`UART_DATA_BITS - 1);

    rx_state_e                  state;
    logic                       rxd_meta;
    logic                       rxd_sync;
    logic                       rxd_prev;
    logic                       start_edge;
    logic                       restart;
    logic                       sample_tick;
    logic                       mid_start;
    logic                       bit_done;
    logic [SMP_W-1:0]           sample_cnt;
    logic [IDX_W-1:0]           bit_cnt;
    logic [`UART_DATA_BITS-1:0] shift_q;
    logic                       parity_bit;

    assign start_edge = rxd_prev && !rxd_sync;
    assign restart    = (state == RX_IDLE) && start_edge && cfg.rx_en;
    assign mid_start  = (state == RX_START) && sample_tick && (sample_cnt == MID_SAMPLE);
    assign bit_done   = sample_tick && (sample_cnt == LAST_SAMPLE);

    baud_controller #(
        .OVERSAMPLE(`UART_OVERSAMPLE)
    ) i_baud_controller (
        .clk     (clk),
        .reset   (reset),
        .baud_sel(cfg.baud_sel),
        .run     (state != RX_IDLE),
        .restart (restart),         // Align ticks to the start edge
        .tick    (sample_tick)
    );

    // Two-flop synchronizer plus edge history, line idles high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= RX_IDLE;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (restart)
                sample_cnt <= '0;
            else if (mid_start)
                sample_cnt <= '0;               // Later samples land mid-bit
            else if (sample_tick)
                sample_cnt <= sample_cnt + 1'b1;    // Wraps every bit
            case (state)
                RX_IDLE: begin
                    if (restart)
                        state <= RX_START;
                end
                RX_START: begin
                    if (mid_start) begin
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;  // Glitch rejected
                        bit_cnt <= '0;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT)
                            state <= RX_PARITY;
                    end
                end
                RX_PARITY: begin
                    if (bit_done)
                        state <= RX_STOP;
                end
                RX_STOP: begin
                    if (bit_done) begin
                        state    <= RX_IDLE;
                        rx_valid <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done)
            shift_q <= {shift_q[`UART_DATA_BITS-2:0], rxd_sync};    // MSB arrives first
        if (state == RX_PARITY && bit_done)
            parity_bit <= rxd_sync;
        if (state == RX_STOP && bit_done) begin
            rx_result <= '{data:         shift_q,
                           parity_error: parity_bit ^ (^shift_q),
                           frame_error:  !rxd_sync};
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else $error("uart_receiver: rx_valid held longer than one cycle");

endmodule

`default_nettype wire

// File: design/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_top (
    input  logic                       clk,
    input  logic                       reset,
    input  uart_cfg_pkg::uart_cfg_t    cfg,
    input  logic [`UART_DATA_BITS-1:0] tx_data,
    input  logic                       tx_wr,
    input  logic                       rxd,
    output logic                       txd,
    output logic                       tx_busy,
    output uart_frame_pkg::rx_result_t rx_result,
    output logic                       rx_valid
);

    // Each endpoint owns its baud controller
    uart_transmitter i_uart_transmitter (
        .clk    (clk),
        .reset  (reset),
        .cfg    (cfg),
        .tx_data(tx_data),
        .tx_wr  (tx_wr),
        .txd    (txd),
        .tx_busy(tx_busy)
    );

    uart_receiver i_uart_receiver (
        .clk      (clk),
        .reset    (reset),
        .cfg      (cfg),
        .rxd      (rxd),
        .rx_result(rx_result),
        .rx_valid (rx_valid)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset drops just after the last reset edge, like other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tb;
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;

    localparam int CORRUPT_NONE   = 0;
    localparam int CORRUPT_PARITY = 1;
    localparam int CORRUPT_STOP   = 2;
    localparam int LOOP_FRAMES    = 20;
    localparam int CORRUPT_FRAMES = 4;
    localparam int CORRUPT_SEL    = 1;

    logic                       clk;
    logic                       reset;
    uart_cfg_t                  cfg;
    logic [`UART_DATA_BITS-1:0] tx_data;
    logic                       tx_wr;
    logic                       txd;
    logic                       rxd;
    logic                       tx_busy;
    rx_result_t                 rx_result;
    logic                       rx_valid;
    logic                       line_invert;        // Corrupts the loopback line
    rx_result_t                 expect_q[$];
    string                      cur_test;
    int                         errors;
    int                         test_err_start;
    int                         tests_passed;
    int                         tests_failed;
    int                         cycle_count;
    int                         cycle_limit;

    tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(3)) i_tb_clock_gen (
        .clk  (clk),
        .reset(reset)
    );

    uart_top i_uart_top (
        .clk(clk), .reset(reset), .cfg(cfg), .tx_data(tx_data), .tx_wr(tx_wr),
        .rxd(rxd), .txd(txd), .tx_busy(tx_busy), .rx_result(rx_result),
        .rx_valid(rx_valid)
    );

    assign rxd = txd ^ line_invert;

    function automatic int clks_per_bit(input int sel);
        case (sel)
            0: return `UART_CLKS_PER_BIT_0;
            1: return `UART_CLKS_PER_BIT_1;
            2: return `UART_CLKS_PER_BIT_2;
            3: return `UART_CLKS_PER_BIT_3;
            4: return `UART_CLKS_PER_BIT_4;
            5: return `UART_CLKS_PER_BIT_5;
            6: return `UART_CLKS_PER_BIT_6;
            default: return `UART_CLKS_PER_BIT_7;
        endcase
    endfunction

    // Sum of all frame lengths the run sends or waits for
    function automatic int planned_cycles();
        int total;
        total = 11 * clks_per_bit(0);                   // Disabled transmitter window
        for (int sel = 0; sel < 8; sel++)
            total += LOOP_FRAMES * 11 * clks_per_bit(sel);
        total += 2 * CORRUPT_FRAMES * 11 * clks_per_bit(CORRUPT_SEL);
        return total;
    endfunction

    // Frame as the receiver should see it after the line corruption
    function automatic rx_result_t expected_result(input logic [7:0] data, input int mode);
        rx_result_t r;
        logic       line_parity;
        logic       line_stop;
        line_parity    = (^data) ^ (mode == CORRUPT_PARITY);   // Even parity as sent
        line_stop      = 1'b1 ^ (mode == CORRUPT_STOP);
        r.data         = data;
        r.parity_error = line_parity ^ (^data);
        r.frame_error  = !line_stop;
        return r;
    endfunction

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic finish_test();
        if (errors == test_err_start) begin
            tests_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_err_start);
        end
    endtask

    // Sends one byte, aims the corruption at a bit and checks busy timing
    task automatic send_frame(input logic [7:0] data, input int mode, input int cpb);
        int k;
        int busy_cycles;
        int wait_cycles;
        expect_q.push_back(expected_result(data, mode));
        assert (!tx_busy) else begin
            $display("Error %s: tx_busy before write expected 0, actual 1", cur_test);
            errors++;
        end
        tx_data = data;
        tx_wr   = 1'b1;
        @(posedge clk);
        #1 tx_wr = 1'b0;
        busy_cycles = 0;
        k = 0;
        while (tx_busy && k <= 12 * cpb) begin
            line_invert = (mode == CORRUPT_PARITY && k >= 9 * cpb && k < 10 * cpb) ||
                          (mode == CORRUPT_STOP && k >= 10 * cpb && k < 11 * cpb);
            busy_cycles++;
            @(posedge clk);
            #1 k++;
        end
        line_invert = 1'b0;
        assert (busy_cycles == 11 * cpb) else begin
            $display("Error %s: tx_busy cycles expected %0d, actual %0d",
                     cur_test, 11 * cpb, busy_cycles);
            errors++;
        end
        wait_cycles = 0;
        while (expect_q.size() > 0 && wait_cycles < 2 * cpb) begin
            @(posedge clk);
            #1 wait_cycles++;
        end
        assert (expect_q.size() == 0) else begin
            $display("No rx_valid came for byte %h in %s", data, cur_test);
            errors++;
            expect_q.delete();
        end
        repeat (2) @(posedge clk);                      // Let DISABLED pass to IDLE
        #1;
    endtask

    task automatic check_disabled_tx(input int cpb);
        int bad;
        bad = 0;
        tx_data = 8'h5a;
        tx_wr   = 1'b1;
        @(posedge clk);
        #1 tx_wr = 1'b0;
        repeat (11 * cpb) begin
            if (tx_busy || !txd)
                bad++;
            @(posedge clk);
            #1;
        end
        assert (bad == 0) else begin
            $display("Error %s: busy or low line cycles expected 0, actual %0d", cur_test, bad);
            errors++;
        end
    endtask

    initial begin : rx_checker
        rx_result_t exp;
        forever begin
            @(negedge clk);
            if (rx_valid) begin
                assert (expect_q.size() > 0) else begin
                    $display("Unexpected rx_valid in %s with no frame in flight", cur_test);
                    errors++;
                end
                if (expect_q.size() > 0) begin
                    exp = expect_q.pop_front();
                    assert (rx_result == exp) else begin
                        $display("Error %s: rx_result expected %h, actual %h",
                                 cur_test, exp, rx_result);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
            @(posedge clk) cycle_count++;
        $display("Run stopped after %0d cycles without finishing", cycle_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        cfg         = '{baud_sel: BAUD_0, tx_en: 1'b1, rx_en: 1'b1};
        tx_data     = '0;
        tx_wr       = 1'b0;
        line_invert = 1'b0;
        errors      = 0;
        cycle_count = 0;
        cur_test    = "reset";
        cycle_limit = planned_cycles() * 3 / 2;
        void'($urandom(27));
        @(negedge reset);
        @(posedge clk);
        #1;
        start_test("reset_state");
        assert ({txd, tx_busy, rx_valid} == 3'b100) else begin
            $display("Error %s: txd/busy/valid expected 100, actual %b%b%b",
                     cur_test, txd, tx_busy, rx_valid);
            errors++;
        end
        finish_test();
        for (int sel = 0; sel < 8; sel++) begin
            cfg.baud_sel = baud_sel_e'(sel);
            start_test($sformatf("loopback_baud%0d", sel));
            repeat (LOOP_FRAMES)
                send_frame(8'($urandom), CORRUPT_NONE, clks_per_bit(sel));
            finish_test();
        end
        cfg.baud_sel = BAUD_0;
        cfg.tx_en    = 1'b0;
        start_test("tx_disabled");
        check_disabled_tx(clks_per_bit(0));
        finish_test();
        cfg.tx_en    = 1'b1;
        cfg.baud_sel = baud_sel_e'(CORRUPT_SEL);
        @(posedge clk);
        #1;
        start_test("parity_error");
        repeat (CORRUPT_FRAMES)
            send_frame(8'($urandom), CORRUPT_PARITY, clks_per_bit(CORRUPT_SEL));
        finish_test();
        start_test("frame_error");
        repeat (CORRUPT_FRAMES)
            send_frame(8'($urandom), CORRUPT_STOP, clks_per_bit(CORRUPT_SEL));
        finish_test();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/uart_cfg_pkg.sv
design/uart_frame_pkg.sv
design/baud_controller.sv
design/uart_transmitter.sv
design/uart_receiver.sv
design/uart_top.sv
sim/tb_clock_gen.sv
sim/uart_tb.sv
